// File: hw/dnc_write_pkg.sv
package dnc_write_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // One element of h, one weight, one result
  localparam int DATA_W = 16;

  // Element and row indices, so L and W are bounded to 256
  localparam int INDEX_W = 8;

  typedef logic [DATA_W-1:0]  data_t;
  typedef logic [INDEX_W-1:0] index_t;

  ////////////////////////////////////////////////////////////////////////////
  // Enums
  ////////////////////////////////////////////////////////////////////////////

  // Interface field a result belongs to, in production order
  typedef enum logic [2:0] {
    FIELD_KEY        = 3'd0,
    FIELD_ERASE      = 3'd1,
    FIELD_VECTOR     = 3'd2,
    FIELD_STRENGTH   = 3'd3,
    FIELD_ALLOC_GATE = 3'd4,
    FIELD_WRITE_GATE = 3'd5
  } field_t;

  // Controller states
  // One load state, six product states, one done state
  typedef enum logic [3:0] {
    ST_IDLE       = 4'd0,
    ST_LOAD_H     = 4'd1,
    ST_KEY        = 4'd2,
    ST_ERASE      = 4'd3,
    ST_VECTOR     = 4'd4,
    ST_STRENGTH   = 4'd5,
    ST_ALLOC_GATE = 4'd6,
    ST_WRITE_GATE = 4'd7,
    ST_DONE       = 4'd8
  } state_t;

  ////////////////////////////////////////////////////////////////////////////
  // Stream beats
  ////////////////////////////////////////////////////////////////////////////

  // Hidden-state and weight streams share this beat
  typedef struct packed {
    data_t data;
  } word_beat_t;

  // Result beat, tagged with field and row index
  typedef struct packed {
    field_t field;
    index_t index;
    data_t  data;
  } result_beat_t;

endpackage

// File: hw/dnc_write_fsm.sv
`timescale 1ns/100ps

module dnc_write_fsm (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  start,
  input  logic                  h_fire,
  input  logic                  beat_fire,
  input  logic                  res_fire,
  input  logic                  elem_last,
  input  logic                  row_last,
  input  logic                  res_pending,
  output dnc_write_pkg::state_t state,
  output dnc_write_pkg::field_t field,
  output logic                  h_ready,
  output logic                  mac_enable,
  output logic                  elem_advance,
  output logic                  row_advance,
  output logic                  busy,
  output logic                  done
);

  import dnc_write_pkg::*;

  state_t state_d;

  // Last write-gate beat taken, now draining the final result
  logic   tail_q;
  logic   product_st;
  logic   matrix_last;
  logic   drained;

  ////////////////////////////////////////////////////////////////////////////
  // Event decode
  ////////////////////////////////////////////////////////////////////////////

  // Any of the six product states
  assign product_st = (state inside {ST_KEY, ST_ERASE, ST_VECTOR,
                                     ST_STRENGTH, ST_ALLOC_GATE, ST_WRITE_GATE});

  // Last element of last row accepted
  assign matrix_last = beat_fire && elem_last && row_last;

  // Final result accepted
  assign drained = tail_q && res_fire;

  ////////////////////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state;
    case (state)
      ST_IDLE:       if (start) state_d = ST_LOAD_H;
      ST_LOAD_H:     if (h_fire && elem_last) state_d = ST_KEY;
      // Product states move on the beat, not on the result
      ST_KEY:        if (matrix_last) state_d = ST_ERASE;
      ST_ERASE:      if (matrix_last) state_d = ST_VECTOR;
      ST_VECTOR:     if (matrix_last) state_d = ST_STRENGTH;
      ST_STRENGTH:   if (matrix_last) state_d = ST_ALLOC_GATE;
      ST_ALLOC_GATE: if (matrix_last) state_d = ST_WRITE_GATE;
      // Last field waits for its own result to leave
      ST_WRITE_GATE: if (drained) state_d = ST_DONE;
      ST_DONE:       state_d = ST_IDLE;
      default:       state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state  <= ST_IDLE;
      tail_q <= 1'b0;
    end else begin
      state <= state_d;
      if (state == ST_WRITE_GATE && matrix_last) begin
        tail_q <= 1'b1;
      end else if (state_d != ST_WRITE_GATE) begin
        tail_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  // Field tag for the row being accumulated
  always_comb begin
    case (state)
      ST_ERASE:      field = FIELD_ERASE;
      ST_VECTOR:     field = FIELD_VECTOR;
      ST_STRENGTH:   field = FIELD_STRENGTH;
      ST_ALLOC_GATE: field = FIELD_ALLOC_GATE;
      ST_WRITE_GATE: field = FIELD_WRITE_GATE;
      default:       field = FIELD_KEY;
    endcase
  end

  assign h_ready    = (state == ST_LOAD_H);
  // No more weights once the last row is in
  assign mac_enable = product_st && !tail_q;
  assign busy       = (state != ST_IDLE);
  assign done       = (state == ST_DONE);

  // Counter steps
  assign elem_advance = h_fire || beat_fire;
  assign row_advance  = beat_fire && elem_last;

  // Done only once the last result has left the data path
  a_done_drained : assert property (@(posedge CLK) disable iff (RST)
    done |-> !res_pending);

endmodule

// File: hw/dnc_write_counter.sv
`timescale 1ns/100ps

module dnc_write_counter #(
  parameter int L_SIZE = 4,
  parameter int W_SIZE = 3
) (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  elem_advance,
  input  logic                  row_advance,
  input  logic                  rows_scalar,
  output dnc_write_pkg::index_t elem_idx,
  output dnc_write_pkg::index_t row_idx,
  output logic                  elem_last,
  output logic                  row_last
);

  import dnc_write_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Last flags
  ////////////////////////////////////////////////////////////////////////////

  assign elem_last = (elem_idx == index_t'(L_SIZE - 1));

  // Scalar fields have a single row
  assign row_last = rows_scalar || (row_idx == index_t'(W_SIZE - 1));

  ////////////////////////////////////////////////////////////////////////////
  // Counters
  ////////////////////////////////////////////////////////////////////////////

  // Element l within a row, or within the h load
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      elem_idx <= '0;
    end else if (elem_advance) begin
      elem_idx <= elem_last ? '0 : elem_idx + 1'b1;
    end
  end

  // Row k within a field
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      row_idx <= '0;
    end else if (row_advance) begin
      row_idx <= row_last ? '0 : row_idx + 1'b1;
    end
  end

  // Buffer reads depend on this bound
  a_elem_range : assert property (@(posedge CLK) disable iff (RST)
    elem_idx < index_t'(L_SIZE));

endmodule

// File: hw/dnc_hidden_buffer.sv
`timescale 1ns/100ps

module dnc_hidden_buffer #(
  parameter int L_SIZE = 4
) (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  wr_en,
  input  dnc_write_pkg::index_t wr_idx,
  input  dnc_write_pkg::data_t  wr_data,
  input  dnc_write_pkg::index_t rd_idx,
  output dnc_write_pkg::data_t  rd_data
);

  import dnc_write_pkg::*;

  // h[0] .. h[L-1], read six times per run
  data_t mem [L_SIZE];

  ////////////////////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < L_SIZE; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      // Decode wr_idx against each entry
      for (int i = 0; i < L_SIZE; i++) begin
        if (wr_idx == index_t'(i)) begin
          mem[i] <= wr_data;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read port
  ////////////////////////////////////////////////////////////////////////////

  // Combinational mux, zero when out of range
  always_comb begin
    rd_data = '0;
    for (int i = 0; i < L_SIZE; i++) begin
      if (rd_idx == index_t'(i)) begin
        rd_data = mem[i];
      end
    end
  end

endmodule

// File: hw/dnc_dot_mac.sv
`timescale 1ns/100ps

module dnc_dot_mac (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        enable,
  input  logic                        w_valid,
  input  dnc_write_pkg::word_beat_t   w_beat,
  output logic                        w_ready,
  input  dnc_write_pkg::data_t        h_elem,
  input  logic                        row_end,
  input  dnc_write_pkg::field_t       tag_field,
  input  dnc_write_pkg::index_t       tag_index,
  output logic                        beat_fire,
  output logic                        res_valid,
  input  logic                        res_ready,
  output dnc_write_pkg::result_beat_t res_beat,
  output logic                        res_fire
);

  import dnc_write_pkg::*;

  // Running row sum
  data_t acc;
  // Product truncated to DATA_W bits
  data_t prod;
  data_t sum;

  ////////////////////////////////////////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////////////////////////////////////////

  // Weights only when the result register is free or emptying
  assign w_ready   = enable && (!res_valid || res_ready);
  assign beat_fire = w_valid && w_ready;
  assign res_fire  = res_valid && res_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Arithmetic, modulo 2^DATA_W
  ////////////////////////////////////////////////////////////////////////////

  assign prod = data_t'(w_beat.data * h_elem);
  assign sum  = acc + prod;

  // Cleared at row end so the next row starts from zero
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      acc <= '0;
    end else if (beat_fire) begin
      acc <= row_end ? '0 : sum;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      res_valid <= 1'b0;
    end else if (beat_fire && row_end) begin
      // Load wins over a same-cycle accept
      res_valid <= 1'b1;
    end else if (res_fire) begin
      res_valid <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (beat_fire && row_end) begin
      res_beat.field <= tag_field;
      res_beat.index <= tag_index;
      res_beat.data  <= sum;
    end
  end

  // Held result is not lost or changed under back-pressure
  a_res_stable : assert property (@(posedge CLK) disable iff (RST)
    res_valid && !res_ready |=> res_valid && $stable(res_beat));

endmodule

// File: hw/dnc_write_interface.sv
`timescale 1ns/100ps

module dnc_write_interface #(
  parameter int L_SIZE = 4,
  parameter int W_SIZE = 3
) (
  input  logic                        CLK,
  input  logic                        RST,

  // Control
  input  logic                        start,
  output logic                        busy,
  output logic                        done,

  // Hidden-state stream
  input  logic                        h_valid,
  output logic                        h_ready,
  input  dnc_write_pkg::word_beat_t   h_beat,

  // Weight stream
  input  logic                        w_valid,
  output logic                        w_ready,
  input  dnc_write_pkg::word_beat_t   w_beat,

  // Result stream
  output logic                        res_valid,
  input  logic                        res_ready,
  output dnc_write_pkg::result_beat_t res_beat
);

  import dnc_write_pkg::*;

  state_t state;
  field_t field;
  index_t elem_idx;
  index_t row_idx;
  data_t  h_elem;
  logic   h_fire;
  logic   beat_fire;
  logic   res_fire;
  logic   elem_last;
  logic   row_last;
  logic   mac_enable;
  logic   elem_advance;
  logic   row_advance;
  logic   rows_scalar;

  // Stream glue
  assign h_fire      = h_valid && h_ready;
  // Strength and both gates are one-row products
  assign rows_scalar = (state inside {ST_STRENGTH, ST_ALLOC_GATE, ST_WRITE_GATE});

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  dnc_write_fsm i_dnc_write_fsm (
    .CLK          (CLK),
    .RST          (RST),
    .start        (start),
    .h_fire       (h_fire),
    .beat_fire    (beat_fire),
    .res_fire     (res_fire),
    .elem_last    (elem_last),
    .row_last     (row_last),
    .res_pending  (res_valid),
    .state        (state),
    .field        (field),
    .h_ready      (h_ready),
    .mac_enable   (mac_enable),
    .elem_advance (elem_advance),
    .row_advance  (row_advance),
    .busy         (busy),
    .done         (done)
  );

  dnc_write_counter #(
    .L_SIZE (L_SIZE),
    .W_SIZE (W_SIZE)
  ) i_dnc_write_counter (
    .CLK          (CLK),
    .RST          (RST),
    .elem_advance (elem_advance),
    .row_advance  (row_advance),
    .rows_scalar  (rows_scalar),
    .elem_idx     (elem_idx),
    .row_idx      (row_idx),
    .elem_last    (elem_last),
    .row_last     (row_last)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Data path
  ////////////////////////////////////////////////////////////////////////////

  // Same element index writes h on load and reads it per weight beat
  dnc_hidden_buffer #(
    .L_SIZE (L_SIZE)
  ) i_dnc_hidden_buffer (
    .CLK     (CLK),
    .RST     (RST),
    .wr_en   (h_fire),
    .wr_idx  (elem_idx),
    .wr_data (h_beat.data),
    .rd_idx  (elem_idx),
    .rd_data (h_elem)
  );

  dnc_dot_mac i_dnc_dot_mac (
    .CLK       (CLK),
    .RST       (RST),
    .enable    (mac_enable),
    .w_valid   (w_valid),
    .w_beat    (w_beat),
    .w_ready   (w_ready),
    .h_elem    (h_elem),
    .row_end   (elem_last),
    .tag_field (field),
    .tag_index (row_idx),
    .beat_fire (beat_fire),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res_beat  (res_beat),
    .res_fire  (res_fire)
  );

endmodule

// File: tb/tb_dnc_write_interface.sv
`timescale 1ns/100ps

module tb_dnc_write_interface;

  import dnc_write_pkg::*;

  localparam int L_SIZE    = 4;
  localparam int W_SIZE    = 3;
  // Three vector fields of W rows, three scalar fields of one row
  localparam int N_RESULTS = 3 * W_SIZE + 3;
  localparam int N_WEIGHTS = N_RESULTS * L_SIZE;
  localparam int NUM_TESTS = 7;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * 8 * (L_SIZE + 6 * W_SIZE * L_SIZE) + 100;

  localparam logic [1:0] MODE_SMALL = 2'd0;
  localparam logic [1:0] MODE_FULL  = 2'd1;
  localparam logic [1:0] MODE_ONES  = 2'd2;

  // One table row, rates in eighths of a cycle
  typedef struct packed {
    logic [1:0] mode;
    logic [3:0] h_gap;
    logic [3:0] w_gap;
    logic [3:0] stall;
  } test_row_t;

  logic         CLK;
  logic         RST;
  logic         start;
  logic         busy;
  logic         done;
  logic         h_valid;
  logic         h_ready;
  word_beat_t   h_beat;
  logic         w_valid;
  logic         w_ready;
  word_beat_t   w_beat;
  logic         res_valid;
  logic         res_ready;
  result_beat_t res_beat;

  test_row_t    tests [NUM_TESTS];
  data_t        h_vals [L_SIZE];
  data_t        w_vals [N_WEIGHTS];
  field_t       exp_field [N_RESULTS];
  index_t       exp_index [N_RESULTS];
  data_t        exp_data [N_RESULTS];
  logic [31:0]  lfsr_state;
  int           check_cnt;
  int           err_cnt;
  int           pass_cnt;
  int           fail_cnt;
  int           cycle_cnt;

  dnc_write_interface #(
    .L_SIZE (L_SIZE),
    .W_SIZE (W_SIZE)
  ) i_dnc_write_interface (.*);

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic data_t make_value(input logic [1:0] mode);
    data_t v;
    case (mode)
      MODE_SMALL: v = data_t'(take_bits(4));
      MODE_FULL:  v = data_t'(take_bits(DATA_W));
      default:    v = '1;
    endcase
    return v;
  endfunction

  // True for a gap cycle, rate out of 8
  function automatic logic gap_now(input logic [3:0] rate);
    return take_bits(3) < {28'd0, rate};
  endfunction

  task automatic verify(input logic cond, input string msg);
    check_cnt++;
    assert (cond) else begin
      $display("CHECK FAILED at %0t ns: %s", $time, msg);
      err_cnt++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Row sums modulo 2^DATA_W, products truncated first
  task automatic compute_expected();
    int pos;
    int n;
    int rows;
    data_t sum;
    logic [2*DATA_W-1:0] prod;
    pos = 0;
    n = 0;
    for (int f = 0; f < 6; f++) begin
      rows = (f < 3) ? W_SIZE : 1;
      for (int k = 0; k < rows; k++) begin
        sum = '0;
        for (int l = 0; l < L_SIZE; l++) begin
          prod = w_vals[pos] * h_vals[l];
          sum = sum + prod[DATA_W-1:0];
          pos++;
        end
        exp_field[n] = field_t'(f);
        exp_index[n] = index_t'(k);
        exp_data[n] = sum;
        n++;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // One run from start to done
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_test(input int t);
    test_row_t row;
    result_beat_t held_beat;
    int h_pos;
    int w_pos;
    int res_cnt;
    int cyc;
    int errs_before;
    logic h_fire;
    logic w_fire;
    logic held;
    logic finished;
    row = tests[t];
    errs_before = err_cnt;
    for (int l = 0; l < L_SIZE; l++) begin
      h_vals[l] = make_value(row.mode);
    end
    for (int i = 0; i < N_WEIGHTS; i++) begin
      w_vals[i] = make_value(row.mode);
    end
    compute_expected();
    h_pos = 0;
    w_pos = 0;
    res_cnt = 0;
    cyc = 0;
    held = 1'b0;
    finished = 1'b0;
    @(posedge CLK);
    #1;
    start = 1'b1;
    while (!finished) begin
      // Handshakes sampled mid-cycle, stable until the next edge
      @(negedge CLK);
      h_fire = h_valid && h_ready;
      w_fire = w_valid && w_ready;
      if (cyc == 1) verify(busy, "busy did not rise after start");
      if (held) verify(res_valid && res_beat == held_beat, "stalled result changed");
      held = res_valid && !res_ready;
      held_beat = res_beat;
      if (held) verify(!w_ready, "weights accepted while a result is stalled");
      if (res_valid && res_ready) begin
        if (res_cnt < N_RESULTS) begin
          verify(res_beat.field == exp_field[res_cnt] && res_beat.index == exp_index[res_cnt]
                 && res_beat.data == exp_data[res_cnt],
                 $sformatf("result %0d is %0d/%0d/%h, expected %0d/%0d/%h", res_cnt,
                           res_beat.field, res_beat.index, res_beat.data, exp_field[res_cnt],
                           exp_index[res_cnt], exp_data[res_cnt]));
        end else begin
          verify(1'b0, "result beyond the expected count");
        end
        res_cnt++;
      end
      if (done) begin
        verify(res_cnt == N_RESULTS, $sformatf("done after %0d results", res_cnt));
        finished = 1'b1;
      end
      cyc++;
      @(posedge CLK);
      #1;
      // Second start lands while busy
      start = (cyc == 4) ? 1'b1 : 1'b0;
      if (h_fire) h_pos++;
      if (w_fire) w_pos++;
      // Valid held until taken
      if (!h_valid || h_fire) begin
        h_valid = (h_pos < L_SIZE) && !gap_now(row.h_gap);
        h_beat.data = (h_pos < L_SIZE) ? h_vals[h_pos] : '0;
      end
      if (!w_valid || w_fire) begin
        w_valid = (w_pos < N_WEIGHTS) && !gap_now(row.w_gap);
        w_beat.data = (w_pos < N_WEIGHTS) ? w_vals[w_pos] : '0;
      end
      res_ready = !gap_now(row.stall);
    end
    @(negedge CLK);
    verify(!done && !busy, "done longer than one cycle or not back to idle");
    verify(h_pos == L_SIZE && w_pos == N_WEIGHTS,
           $sformatf("took %0d h beats and %0d weight beats", h_pos, w_pos));
    if (err_cnt == errs_before) pass_cnt++;
    else fail_cnt++;
    $display("Test %0d mode %0d gaps %0d/%0d stall %0d: %s, %0d cycles", t, row.mode,
             row.h_gap, row.w_gap, row.stall, (err_cnt == errs_before) ? "ok" : "errors", cyc);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and timeout
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    RST = 1'b1;
    start = 1'b0;
    h_valid = 1'b0;
    h_beat = '0;
    w_valid = 1'b0;
    w_beat = '0;
    res_ready = 1'b0;
    lfsr_state = 32'hcb51425a;
    check_cnt = 0;
    err_cnt = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    // Mode, h gap, w gap, stall
    tests[0] = '{MODE_SMALL, 4'd0, 4'd0, 4'd0};
    tests[1] = '{MODE_SMALL, 4'd2, 4'd2, 4'd0};
    tests[2] = '{MODE_FULL, 4'd0, 4'd0, 4'd3};
    tests[3] = '{MODE_FULL, 4'd3, 4'd3, 4'd3};
    tests[4] = '{MODE_ONES, 4'd0, 4'd0, 4'd0};
    tests[5] = '{MODE_ONES, 4'd4, 4'd4, 4'd4};
    tests[6] = '{MODE_FULL, 4'd2, 4'd4, 4'd4};
    repeat (3) @(posedge CLK);
    #1;
    RST = 1'b0;
    @(negedge CLK);
    verify(!busy && !done && !h_ready && !w_ready && !res_valid, "outputs not low after reset");
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("Tests %0d ok, %0d with errors; checks %0d, errors %0d",
             pass_cnt, fail_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge CLK);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// File: dnc_write_interface.f
hw/dnc_write_pkg.sv
hw/dnc_write_fsm.sv
hw/dnc_write_counter.sv
hw/dnc_hidden_buffer.sv
hw/dnc_dot_mac.sv
hw/dnc_write_interface.sv
tb/tb_dnc_write_interface.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_dnc_write_interface \
  -f dnc_write_interface.f
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

output="$(./obj_dir/Vtb_dnc_write_interface)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "PASS: all tests" <<< "$output"; then
  exit 0
fi
exit 1
